// File: run_sim.sh
#!/bin/sh
# build and run the rv_exu testbench under verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_exu -Mdir obj_dir -f rv_exu.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_exu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

// File: rv_exu.f
+incdir+verif
verilog/exu_pkg.sv
verilog/exu_operand_sel.sv
verilog/exu_alu.sv
verilog/exu_branch.sv
verilog/exu_mem_reg.sv
verilog/exu_top.sv
verif/tb_exu.sv

// File: verif/exu_model.svh
/* execute stage reference model */

`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

logic [31:0] lcg_state;

// upper halves of two lcg steps, the low bits repeat too soon
function automatic logic [31:0] rand32();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    hi = lcg_state[31:16];
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {hi, lcg_state[31:16]};
endfunction

function automatic logic [XLEN-1:0] rand64();
    return {rand32(), rand32()};
endfunction

function automatic logic rand_bit();
    return rand32() >= 32'h8000_0000;
endfunction

// ============================================================
// expected results
// ============================================================
function automatic logic [XLEN-1:0] model_alu(input logic [ALU_OP_W-1:0] op, input logic word,
                                              input logic [XLEN-1:0] a, b);
    logic [XLEN-1:0] r;
    logic [5:0]      sh;
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    case (op)
        ALU_ADD:  r = a + b;
        ALU_SUB:  r = a - b;
        ALU_SLT:  r = word ? XLEN'($signed(a[31:0]) < $signed(b[31:0]))
                           : XLEN'($signed(a) < $signed(b));
        ALU_SLTU: r = word ? XLEN'(a[31:0] < b[31:0]) : XLEN'(a < b);
        ALU_OR:   r = a | b;
        ALU_AND:  r = a & b;
        ALU_XOR:  r = a ^ b;
        ALU_SLL:  r = a << sh;
        ALU_SRL:  r = word ? XLEN'(a[31:0] >> sh) : a >> sh;
        ALU_SRA:  r = word ? XLEN'($signed(a[31:0]) >>> sh) : $signed(a) >>> sh;
        default:  r = '0;
    endcase
    // word ops keep the low half sign extended
    return word ? {{32{r[31]}}, r[31:0]} : r;
endfunction

function automatic logic [XLEN-1:0] model_csr(input logic [CSR_OP_W-1:0] op,
                                              input logic [XLEN-1:0] rs1_v, csr_v);
    if (op == CSR_RW)
        return rs1_v;
    if (op == CSR_RS)
        return csr_v | rs1_v;
    return '0;
endfunction

function automatic logic model_taken(input logic v, input logic [BR_W-1:0] kind,
                                     input logic less, zero);
    return v && ((kind == BR_JUMP) || (kind == BR_EQ && zero) || (kind == BR_NE && !zero)
                 || (kind == BR_LT && less) || (kind == BR_GE && !less));
endfunction

function automatic logic [XLEN-1:0] model_target(input logic [TGT_W-1:0] sel,
                                                 input logic [XLEN-1:0] pc_v, imm_v, rs1_v, csr_v);
    if (sel == TGT_RS1)
        return (rs1_v + imm_v) & ~XLEN'(1);
    if (sel == TGT_CSR)
        return csr_v + imm_v;
    return pc_v + imm_v;
endfunction

`endif

// File: verif/tb_exu.sv
/* execute stage testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_exu
    import exu_pkg::*;
();

    localparam int M_IDLE = 0;
    localparam int M_ALU  = 1;
    localparam int M_CSR  = 2;
    localparam int M_BR   = 3;

    logic clk, reset, valid, write_gpr, word_op, stall, fwd_rs1_hit, fwd_rs2_hit, fwd_csr_hit;
    logic [XLEN-1:0] pc, imm, rs1_data, rs2_data, csr_data;
    logic [XLEN-1:0] fwd_rs1_data, fwd_rs2_data, fwd_csr_data;
    logic [GPR_W-1:0] rd, mem_rd;
    logic [ALU_OP_W-1:0] alu_op;
    logic [SRC_A_W-1:0] src_a;
    logic [SRC_B_W-1:0] src_b;
    logic [BR_W-1:0] br_kind;
    logic [TGT_W-1:0] br_target_sel;
    logic [CSR_OP_W-1:0] csr_op;
    logic branch_taken, mem_valid, mem_write_gpr;
    logic [XLEN-1:0] branch_target, mem_pc, mem_alu_result, mem_csr_result, mem_store_data;

    // ex/mem model and expected values for the inputs on the bus
    logic exp_valid, exp_wgpr, cur_taken;
    logic [GPR_W-1:0] exp_rd;
    logic [XLEN-1:0] exp_pc, exp_alu, exp_csr, exp_store;
    logic [XLEN-1:0] cur_alu, cur_csr, cur_store, cur_target;
    int errors, checks, test_errors;

    `include "exu_model.svh"

    exu_top u_dut (.*);

    always #10 clk = ~clk;

    task automatic check_data(input string name, input logic [XLEN-1:0] exp_v, act);
        checks++;
        if (act !== exp_v) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp_v, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, act);
        checks++;
        if (act !== exp_v) begin
            $display("FAIL %0t %s expected %b actual %b", $time, name, exp_v, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_rd(input string name, input logic [GPR_W-1:0] exp_v, act);
        checks++;
        if (act !== exp_v) begin
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp_v, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic drive_inputs(input int mode, input bit stall_en, input bit rst);
        reset         <= rst;
        // random valid under reset so the clear of mem_valid shows
        valid         <= rst ? rand_bit() : (mode != M_IDLE);
        write_gpr     <= rand_bit();
        rd            <= GPR_W'(rand32());
        pc            <= rand64();
        imm           <= rand64();
        rs1_data      <= rand64();
        rs2_data      <= rand64();
        csr_data      <= rand64();
        fwd_rs1_data  <= rand64();
        fwd_rs2_data  <= rand64();
        fwd_csr_data  <= rand64();
        fwd_rs1_hit   <= rand_bit();
        fwd_rs2_hit   <= rand_bit();
        fwd_csr_hit   <= rand_bit();
        alu_op        <= ALU_OP_W'(rand32() % 10);
        word_op       <= rand_bit();
        src_a         <= rand_bit();
        src_b         <= SRC_B_W'(rand32());
        br_target_sel <= TGT_W'(rand32() % 3);
        br_kind       <= (mode == M_BR || mode == M_IDLE) ? BR_W'(rand32() % 6) : BR_NONE;
        csr_op        <= (mode == M_CSR) ? (rand_bit() ? CSR_RS : CSR_RW) : CSR_NONE;
        stall         <= stall_en && (rand32() % 3 == 0);
    endtask

    task automatic predict();
        logic [XLEN-1:0] rs1_v, rs2_v, csr_v, b;
        rs1_v = fwd_rs1_hit ? fwd_rs1_data : rs1_data;
        rs2_v = fwd_rs2_hit ? fwd_rs2_data : rs2_data;
        csr_v = fwd_csr_hit ? fwd_csr_data : csr_data;
        b = (src_b == SRC_B_RS2) ? rs2_v : (src_b == SRC_B_IMM) ? imm
          : (src_b == SRC_B_FOUR) ? XLEN'(4) : csr_v;
        cur_alu    = model_alu(alu_op, word_op, (src_a == SRC_A_PC) ? pc : rs1_v, b);
        cur_csr    = model_csr(csr_op, rs1_v, csr_v);
        cur_store  = rs2_v;
        cur_taken  = model_taken(valid, br_kind,
                                 (alu_op == ALU_SLT || alu_op == ALU_SLTU) && cur_alu[0],
                                 cur_alu == '0);
        cur_target = model_target(br_target_sel, pc, imm, rs1_v, csr_v);
    endtask

    task automatic run_cycle(input int mode, input bit stall_en, input bit rst);
        @(posedge clk);
        // model takes the same edge as the ex/mem register
        if (reset)
            {exp_valid, exp_wgpr, exp_rd, exp_pc, exp_alu, exp_csr, exp_store} = '0;
        else if (!stall)
            {exp_valid, exp_wgpr, exp_rd, exp_pc, exp_alu, exp_csr, exp_store} =
                {valid, write_gpr, rd, pc, cur_alu, cur_csr, cur_store};
        drive_inputs(mode, stall_en, rst);
        @(negedge clk);
        predict();
        check_bit("mem_valid", exp_valid, mem_valid);
        check_bit("mem_write_gpr", exp_wgpr, mem_write_gpr);
        check_rd("mem_rd", exp_rd, mem_rd);
        check_data("mem_pc", exp_pc, mem_pc);
        check_data("mem_alu_result", exp_alu, mem_alu_result);
        check_data("mem_csr_result", exp_csr, mem_csr_result);
        check_data("mem_store_data", exp_store, mem_store_data);
        check_bit("branch_taken", cur_taken, branch_taken);
        if (cur_taken)
            check_data("branch_target", cur_target, branch_target);
    endtask

    task automatic report_test(input string name);
        $display("test %s done, %0d mismatches", name, test_errors);
        test_errors = 0;
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        int i;
        lcg_state = 32'd84;
        errors = 0;
        checks = 0;
        test_errors = 0;
        clk = 1'b0;
        drive_inputs(M_IDLE, 1'b0, 1'b1);
        for (i = 0; i < 8; i++)
            run_cycle(M_IDLE, 1'b0, i < 7);
        check_bit("mem_valid", 1'b0, mem_valid);
        check_bit("mem_write_gpr", 1'b0, mem_write_gpr);
        check_bit("branch_taken", 1'b0, branch_taken);
        report_test("reset");
        for (i = 0; i < 400; i++)
            run_cycle(M_ALU, 1'b0, 1'b0);
        report_test("alu");
        for (i = 0; i < 200; i++)
            run_cycle(M_CSR, 1'b0, 1'b0);
        report_test("csr");
        for (i = 0; i < 300; i++)
            run_cycle(M_BR, 1'b0, 1'b0);
        report_test("branch");
        // mixed traffic with random stalls
        for (i = 0; i < 300; i++)
            run_cycle(M_ALU + int'(rand32() % 3), 1'b1, 1'b0);
        report_test("stall");
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/exu_alu.sv
/* integer alu and csr write value */

`timescale 1ns/1ps
`default_nettype none

module exu_alu
    import exu_pkg::*;
(
    input  logic [XLEN-1:0]     op_a,
    input  logic [XLEN-1:0]     op_b,
    input  logic [XLEN-1:0]     rs1_val,
    input  logic [XLEN-1:0]     csr_val,
    input  logic [ALU_OP_W-1:0] alu_op,
    input  logic                word_op,
    input  logic [CSR_OP_W-1:0] csr_op,
    output logic [XLEN-1:0]     alu_result,
    output logic [XLEN-1:0]     csr_result,
    output logic                alu_less,
    output logic                alu_zero
);

    logic [XLEN-1:0]         in_a;
    logic [XLEN-1:0]         in_b;
    logic [XLEN-1:0]         srl_a;
    logic [XLEN-1:0]         raw;
    logic [$clog2(XLEN)-1:0] shamt;
    logic                    signed_lt;
    logic                    unsigned_lt;

    // ============================================================
    // operand conditioning
    // ============================================================
    // word ops run on sign extended low halves, srl needs zero fill
    always_comb begin
        if (word_op) begin
            in_a  = {{(XLEN-WORD_W){op_a[WORD_W-1]}}, op_a[WORD_W-1:0]};
            in_b  = {{(XLEN-WORD_W){op_b[WORD_W-1]}}, op_b[WORD_W-1:0]};
            srl_a = {{(XLEN-WORD_W){1'b0}}, op_a[WORD_W-1:0]};
            shamt = $clog2(XLEN)'(op_b[$clog2(WORD_W)-1:0]);
        end else begin
            in_a  = op_a;
            in_b  = op_b;
            srl_a = op_a;
            shamt = op_b[$clog2(XLEN)-1:0];
        end
    end

    // sign extension keeps unsigned order too
    assign signed_lt   = $signed(in_a) < $signed(in_b);
    assign unsigned_lt = in_a < in_b;

    // ============================================================
    // operation select
    // ============================================================
    always_comb begin
        raw = '0;
        case (alu_op)
            ALU_ADD:  raw = in_a + in_b;
            ALU_SUB:  raw = in_a - in_b;
            ALU_SLT:  raw = XLEN'(signed_lt);
            ALU_SLTU: raw = XLEN'(unsigned_lt);
            ALU_OR:   raw = in_a | in_b;
            ALU_AND:  raw = in_a & in_b;
            ALU_XOR:  raw = in_a ^ in_b;
            ALU_SLL:  raw = in_a << shamt;
            ALU_SRL:  raw = srl_a >> shamt;
            ALU_SRA:  raw = $signed(in_a) >>> shamt;
            default:  raw = '0;
        endcase
    end

    assign alu_result = word_op ? {{(XLEN-WORD_W){raw[WORD_W-1]}}, raw[WORD_W-1:0]} : raw;

    // flags for the branch unit
    assign alu_less = ((alu_op == ALU_SLT) || (alu_op == ALU_SLTU)) && alu_result[0];
    assign alu_zero = (alu_result == '0);

    // ============================================================
    // csr write value
    // ============================================================
    always_comb begin
        case (csr_op)
            CSR_RW:  csr_result = rs1_val;
            CSR_RS:  csr_result = csr_val | rs1_val;
            default: csr_result = '0;
        endcase
    end

    // mul/div codes are not decoded into this stage
    a_alu_op_legal : assert final (alu_op <= ALU_SRA)
        else $error("alu: illegal alu_op %0d", alu_op);

endmodule

`default_nettype wire

// File: verilog/exu_branch.sv
/* branch resolution */

`timescale 1ns/1ps
`default_nettype none

module exu_branch
    import exu_pkg::*;
(
    input  logic              valid,
    input  logic [XLEN-1:0]   pc,
    input  logic [XLEN-1:0]   imm,
    input  logic [XLEN-1:0]   rs1_val,
    input  logic [XLEN-1:0]   csr_val,
    input  logic              alu_less,
    input  logic              alu_zero,
    input  logic [BR_W-1:0]   br_kind,
    input  logic [TGT_W-1:0]  br_target_sel,
    output logic              branch_taken,
    output logic [XLEN-1:0]   branch_target
);

    logic            cond;
    logic [XLEN-1:0] rs1_sum;

    // eq/ne rely on a sub in the alu, lt/ge on slt or sltu
    always_comb begin
        case (br_kind)
            BR_JUMP: cond = 1'b1;
            BR_EQ:   cond = alu_zero;
            BR_NE:   cond = !alu_zero;
            BR_LT:   cond = alu_less;
            BR_GE:   cond = !alu_less;
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = valid && cond;

    // jalr drops bit 0
    assign rs1_sum = rs1_val + imm;

    always_comb begin
        case (br_target_sel)
            TGT_RS1: branch_target = {rs1_sum[XLEN-1:1], 1'b0};
            TGT_CSR: branch_target = csr_val + imm;
            default: branch_target = pc + imm;
        endcase
    end

    // only defined kinds and target selects come from decode
    a_branch_legal : assert final ((br_kind <= BR_GE) && (br_target_sel <= TGT_CSR))
        else $error("branch: illegal kind %0d or target %0d", br_kind, br_target_sel);

endmodule

`default_nettype wire

// File: verilog/exu_mem_reg.sv
/* ex/mem pipeline register */

`timescale 1ns/1ps
`default_nettype none

module exu_mem_reg
    import exu_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  logic              valid,
    input  logic              write_gpr,
    input  logic [XLEN-1:0]   pc,
    input  logic [XLEN-1:0]   alu_result,
    input  logic [XLEN-1:0]   csr_result,
    input  logic [XLEN-1:0]   store_data,
    input  logic [GPR_W-1:0]  rd,
    output logic              mem_valid,
    output logic              mem_write_gpr,
    output logic [XLEN-1:0]   mem_pc,
    output logic [XLEN-1:0]   mem_alu_result,
    output logic [XLEN-1:0]   mem_csr_result,
    output logic [XLEN-1:0]   mem_store_data,
    output logic [GPR_W-1:0]  mem_rd
);

    // reset first, then hold while the forwarding unit stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid      <= 1'b0;
            mem_write_gpr  <= 1'b0;
            mem_pc         <= '0;
            mem_alu_result <= '0;
            mem_csr_result <= '0;
            mem_store_data <= '0;
            mem_rd         <= '0;
        end else if (!stall) begin
            mem_valid      <= valid;
            mem_write_gpr  <= write_gpr;
            mem_pc         <= pc;
            mem_alu_result <= alu_result;
            mem_csr_result <= csr_result;
            mem_store_data <= store_data;
            mem_rd         <= rd;
        end
    end

    // ============================================================
    // checks
    // ============================================================
    a_reset_clears : assert property (@(posedge clk) reset |=> !mem_valid)
        else $error("mem_reg: mem_valid set after reset");

    a_stall_holds : assert property (@(posedge clk) (stall && !reset) |=>
        $stable({mem_valid, mem_write_gpr, mem_pc, mem_alu_result,
                 mem_csr_result, mem_store_data, mem_rd}))
        else $error("mem_reg: outputs moved during stall");

endmodule

`default_nettype wire

// File: verilog/exu_operand_sel.sv
/* operand select with forwarding */

`timescale 1ns/1ps
`default_nettype none

module exu_operand_sel
    import exu_pkg::*;
(
    input  logic [XLEN-1:0]    pc,
    input  logic [XLEN-1:0]    imm,
    input  logic [XLEN-1:0]    rs1_data,
    input  logic [XLEN-1:0]    rs2_data,
    input  logic [XLEN-1:0]    csr_data,
    input  logic [XLEN-1:0]    fwd_rs1_data,
    input  logic [XLEN-1:0]    fwd_rs2_data,
    input  logic [XLEN-1:0]    fwd_csr_data,
    input  logic               fwd_rs1_hit,
    input  logic               fwd_rs2_hit,
    input  logic               fwd_csr_hit,
    input  logic [SRC_A_W-1:0] src_a,
    input  logic [SRC_B_W-1:0] src_b,
    output logic [XLEN-1:0]    rs1_val,
    output logic [XLEN-1:0]    rs2_val,
    output logic [XLEN-1:0]    csr_val,
    output logic [XLEN-1:0]    op_a,
    output logic [XLEN-1:0]    op_b
);

    // newer value from a later stage wins over the register file
    assign rs1_val = fwd_rs1_hit ? fwd_rs1_data : rs1_data;
    assign rs2_val = fwd_rs2_hit ? fwd_rs2_data : rs2_data;
    assign csr_val = fwd_csr_hit ? fwd_csr_data : csr_data;

    assign op_a = (src_a == SRC_A_PC) ? pc : rs1_val;

    always_comb begin
        op_b = rs2_val;
        case (src_b)
            SRC_B_RS2:  op_b = rs2_val;
            SRC_B_IMM:  op_b = imm;
            SRC_B_FOUR: op_b = XLEN'(4);
            SRC_B_CSR:  op_b = csr_val;
        endcase
    end

    // decoder must hand over a defined source code
    a_src_known : assert final (!$isunknown({src_a, src_b}))
        else $error("operand_sel: undefined src_a or src_b");

endmodule

`default_nettype wire

// File: verilog/exu_pkg.sv
/* execute stage shared definitions */

`default_nettype none

package exu_pkg;

    // ============================================================
    // widths
    // ============================================================
    localparam int XLEN   = 64;
    localparam int WORD_W = 32;
    localparam int GPR_W  = 5;
    localparam int CSR_W  = 12;

    localparam int ALU_OP_W = 4;
    localparam int SRC_A_W  = 1;
    localparam int SRC_B_W  = 2;
    localparam int BR_W     = 3;
    localparam int TGT_W    = 2;
    localparam int CSR_OP_W = 2;

    // ============================================================
    // alu operations
    // ============================================================
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = ALU_OP_W'(0);
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = ALU_OP_W'(1);
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = ALU_OP_W'(2);
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = ALU_OP_W'(3);
    localparam logic [ALU_OP_W-1:0] ALU_OR   = ALU_OP_W'(4);
    localparam logic [ALU_OP_W-1:0] ALU_AND  = ALU_OP_W'(5);
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = ALU_OP_W'(6);
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = ALU_OP_W'(7);
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = ALU_OP_W'(8);
    // highest legal code
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = ALU_OP_W'(9);

    // ============================================================
    // operand sources
    // ============================================================
    localparam logic [SRC_A_W-1:0] SRC_A_RS1 = SRC_A_W'(0);
    localparam logic [SRC_A_W-1:0] SRC_A_PC  = SRC_A_W'(1);

    localparam logic [SRC_B_W-1:0] SRC_B_RS2  = SRC_B_W'(0);
    localparam logic [SRC_B_W-1:0] SRC_B_IMM  = SRC_B_W'(1);
    // return address for jal/jalr
    localparam logic [SRC_B_W-1:0] SRC_B_FOUR = SRC_B_W'(2);
    localparam logic [SRC_B_W-1:0] SRC_B_CSR  = SRC_B_W'(3);

    // ============================================================
    // branch kinds and target selects
    // ============================================================
    localparam logic [BR_W-1:0] BR_NONE = BR_W'(0);
    localparam logic [BR_W-1:0] BR_JUMP = BR_W'(1);
    localparam logic [BR_W-1:0] BR_EQ   = BR_W'(2);
    localparam logic [BR_W-1:0] BR_NE   = BR_W'(3);
    localparam logic [BR_W-1:0] BR_LT   = BR_W'(4);
    localparam logic [BR_W-1:0] BR_GE   = BR_W'(5);

    localparam logic [TGT_W-1:0] TGT_PC  = TGT_W'(0);
    localparam logic [TGT_W-1:0] TGT_RS1 = TGT_W'(1);
    // mret style return through a csr
    localparam logic [TGT_W-1:0] TGT_CSR = TGT_W'(2);

    // ============================================================
    // csr write operations
    // ============================================================
    localparam logic [CSR_OP_W-1:0] CSR_NONE = CSR_OP_W'(0);
    localparam logic [CSR_OP_W-1:0] CSR_RW   = CSR_OP_W'(1);
    localparam logic [CSR_OP_W-1:0] CSR_RS   = CSR_OP_W'(2);

endpackage

`default_nettype wire

// File: verilog/exu_top.sv
/* rv64 execute stage */

`timescale 1ns/1ps
`default_nettype none

module exu_top
    import exu_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    // decoded instruction
    input  logic                valid,
    input  logic [XLEN-1:0]     pc,
    input  logic [XLEN-1:0]     imm,
    input  logic [GPR_W-1:0]    rd,
    input  logic                write_gpr,
    input  logic [XLEN-1:0]     rs1_data,
    input  logic [XLEN-1:0]     rs2_data,
    input  logic [XLEN-1:0]     csr_data,
    input  logic [ALU_OP_W-1:0] alu_op,
    input  logic                word_op,
    input  logic [SRC_A_W-1:0]  src_a,
    input  logic [SRC_B_W-1:0]  src_b,
    input  logic [BR_W-1:0]     br_kind,
    input  logic [TGT_W-1:0]    br_target_sel,
    input  logic [CSR_OP_W-1:0] csr_op,
    // forwarding unit
    input  logic [XLEN-1:0]     fwd_rs1_data,
    input  logic [XLEN-1:0]     fwd_rs2_data,
    input  logic [XLEN-1:0]     fwd_csr_data,
    input  logic                fwd_rs1_hit,
    input  logic                fwd_rs2_hit,
    input  logic                fwd_csr_hit,
    input  logic                stall,
    // fetch redirect
    output logic                branch_taken,
    output logic [XLEN-1:0]     branch_target,
    // to mem stage
    output logic                mem_valid,
    output logic                mem_write_gpr,
    output logic [XLEN-1:0]     mem_pc,
    output logic [XLEN-1:0]     mem_alu_result,
    output logic [XLEN-1:0]     mem_csr_result,
    output logic [XLEN-1:0]     mem_store_data,
    output logic [GPR_W-1:0]    mem_rd
);

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] csr_val;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] csr_result;
    logic            alu_less;
    logic            alu_zero;

    exu_operand_sel u_operand_sel (
        .pc(pc), .imm(imm),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .csr_data(csr_data),
        .fwd_rs1_data(fwd_rs1_data), .fwd_rs2_data(fwd_rs2_data),
        .fwd_csr_data(fwd_csr_data),
        .fwd_rs1_hit(fwd_rs1_hit), .fwd_rs2_hit(fwd_rs2_hit), .fwd_csr_hit(fwd_csr_hit),
        .src_a(src_a), .src_b(src_b),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .csr_val(csr_val),
        .op_a(op_a), .op_b(op_b)
    );

    exu_alu u_alu (
        .op_a(op_a), .op_b(op_b), .rs1_val(rs1_val), .csr_val(csr_val),
        .alu_op(alu_op), .word_op(word_op), .csr_op(csr_op),
        .alu_result(alu_result), .csr_result(csr_result),
        .alu_less(alu_less), .alu_zero(alu_zero)
    );

    exu_branch u_branch (
        .valid(valid), .pc(pc), .imm(imm), .rs1_val(rs1_val), .csr_val(csr_val),
        .alu_less(alu_less), .alu_zero(alu_zero),
        .br_kind(br_kind), .br_target_sel(br_target_sel),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    // resolved rs2 becomes the store data
    exu_mem_reg u_mem_reg (
        .clk(clk), .reset(reset), .stall(stall),
        .valid(valid), .write_gpr(write_gpr), .pc(pc),
        .alu_result(alu_result), .csr_result(csr_result), .store_data(rs2_val), .rd(rd),
        .mem_valid(mem_valid), .mem_write_gpr(mem_write_gpr), .mem_pc(mem_pc),
        .mem_alu_result(mem_alu_result), .mem_csr_result(mem_csr_result),
        .mem_store_data(mem_store_data), .mem_rd(mem_rd)
    );

endmodule

`default_nettype wire
